/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ========================================================================
    // Basic types
    // ========================================================================

    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [4:0] reg_addr_t;

    // ========================================================================
    // Instruction formats
    // ========================================================================

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ========================================================================
    // Encodings
    // ========================================================================

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SB = 3'b000;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam word_t RESET_PC = 32'h0000_0000;
    // ADDI x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_INSTR,
        EXECUTE,
        MEM_REQ,
        WAIT_LOAD,
        WRITEBACK
    } cpu_state_e;

endpackage

`default_nettype wire

/* src/operand_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface operand_if;
    import cpu_pkg::*;

    instr_u instruction;
    word_t pc;
    word_t rs1_data;
    word_t rs2_data;

    // Instruction and pc come from control, operands from the register file
    modport source (
        output instruction,
        output pc,
        output rs1_data,
        output rs2_data
    );

    modport sink (
        input instruction,
        input pc,
        input rs1_data,
        input rs2_data
    );

endinterface

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input wire clk,
    input wire reset,

    input wire cpu_pkg::reg_addr_t read_addr1,
    output cpu_pkg::word_t read_data1,

    input wire cpu_pkg::reg_addr_t read_addr2,
    output cpu_pkg::word_t read_data2,

    input wire write_enable,
    input wire cpu_pkg::reg_addr_t write_addr,
    input wire cpu_pkg::word_t write_data
);
    import cpu_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data1 = (read_addr1 == 5'd0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == 5'd0) ? '0 : regs[read_addr2];

    a_write_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        write_enable |-> !$isunknown(write_addr)
    );

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    operand_if.sink ops,

    output cpu_pkg::word_t result,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t store_data,
    output cpu_pkg::byte_en_t store_byte_en
);
    import cpu_pkg::*;

    instr_u instr;
    word_t imm_i;
    word_t imm_s;
    word_t operand_b;
    logic is_reg_op;
    logic is_sub;

    assign instr = ops.instruction;
    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};

    assign is_reg_op = (instr.r_fmt.opcode == OP_REG);
    assign is_sub = is_reg_op && (instr.r_fmt.funct7 == F7_SUB);
    assign operand_b = is_reg_op ? ops.rs2_data : imm_i;

    always_comb begin
        result = '0;
        if (instr.u_fmt.opcode == OP_LUI) begin
            result = {instr.u_fmt.imm, 12'd0};
        end else if (is_reg_op || instr.i_fmt.opcode == OP_IMM) begin
            case (instr.r_fmt.funct3)
                F3_ADD: result = is_sub ? ops.rs1_data - operand_b
                                        : ops.rs1_data + operand_b;
                F3_SLT: result = {31'd0, $signed(ops.rs1_data) < $signed(operand_b)};
                F3_SLTU: result = {31'd0, ops.rs1_data < operand_b};
                F3_XOR: result = ops.rs1_data ^ operand_b;
                F3_OR: result = ops.rs1_data | operand_b;
                F3_AND: result = ops.rs1_data & operand_b;
                default: result = '0;
            endcase
        end
    end

    // Effective address for LW, SW and SB
    assign mem_addr = ops.rs1_data + ((instr.s_fmt.opcode == OP_STORE) ? imm_s : imm_i);

    always_comb begin
        store_data = ops.rs2_data;
        store_byte_en = 4'b1111;
        if (instr.s_fmt.opcode == OP_STORE && instr.s_fmt.funct3 == F3_SB) begin
            // Replicate the byte, the enable picks the lane
            store_data = {4{ops.rs2_data[7:0]}};
            store_byte_en = 4'b0001 << mem_addr[1:0];
        end
    end

endmodule

`default_nettype wire

/* src/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    operand_if.sink ops,

    output cpu_pkg::word_t next_pc,
    output cpu_pkg::word_t link
);
    import cpu_pkg::*;

    instr_u instr;
    word_t b_offset;
    word_t j_offset;
    logic taken;

    assign instr = ops.instruction;

    assign b_offset = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign j_offset = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        taken = 1'b0;
        if (instr.b_fmt.opcode == OP_BRANCH) begin
            case (instr.b_fmt.funct3)
                F3_BEQ: taken = (ops.rs1_data == ops.rs2_data);
                F3_BNE: taken = (ops.rs1_data != ops.rs2_data);
                F3_BLT: taken = ($signed(ops.rs1_data) < $signed(ops.rs2_data));
                F3_BGE: taken = ($signed(ops.rs1_data) >= $signed(ops.rs2_data));
                default: taken = 1'b0;
            endcase
        end
    end

    assign link = ops.pc + 32'd4;

    always_comb begin
        if (instr.j_fmt.opcode == OP_JAL) begin
            next_pc = ops.pc + j_offset;
        end else if (taken) begin
            next_pc = ops.pc + b_offset;
        end else begin
            next_pc = link;
        end
    end

endmodule

`default_nettype wire

/* src/writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input wire retire,
    input wire cpu_pkg::instr_u instruction,

    input wire cpu_pkg::word_t alu_result,
    input wire cpu_pkg::word_t load_data,
    input wire cpu_pkg::word_t link,
    input wire cpu_pkg::word_t next_pc,

    output logic reg_write_enable,
    output cpu_pkg::reg_addr_t reg_write_addr,
    output cpu_pkg::word_t reg_write_data,

    output logic pc_write_enable,
    output cpu_pkg::word_t pc_write_data
);
    import cpu_pkg::*;

    logic has_rd;

    // Stores and branches have no destination register
    always_comb begin
        case (instruction.r_fmt.opcode)
            OP_REG, OP_IMM, OP_LUI, OP_LOAD, OP_JAL: has_rd = 1'b1;
            default: has_rd = 1'b0;
        endcase
    end

    always_comb begin
        case (instruction.r_fmt.opcode)
            OP_LOAD: reg_write_data = load_data;
            OP_JAL: reg_write_data = link;
            default: reg_write_data = alu_result;
        endcase
    end

    assign reg_write_enable = retire && has_rd;
    assign reg_write_addr = instruction.r_fmt.rd;

    // Every retired instruction moves the pc, branch unit already picked the target
    assign pc_write_enable = retire;
    assign pc_write_data = next_pc;

endmodule

`default_nettype wire

/* src/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
    input wire clk,
    input wire reset,

    input wire system_bus_ready,
    output cpu_pkg::word_t system_bus_addr,
    output cpu_pkg::word_t system_bus_write_data,
    output cpu_pkg::byte_en_t system_bus_byte_enable,
    output logic system_bus_write_req,
    output logic system_bus_read_req,
    input wire cpu_pkg::word_t system_bus_read_data,
    input wire system_bus_read_data_valid,

    input wire cpu_pkg::word_t mem_addr,
    input wire cpu_pkg::word_t store_data,
    input wire cpu_pkg::byte_en_t store_byte_en,

    input wire pc_write_enable,
    input wire cpu_pkg::word_t pc_write_data,

    output cpu_pkg::instr_u instruction,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t load_data,
    output logic retire
);
    import cpu_pkg::*;

    cpu_state_e state;
    cpu_state_e state_next;
    logic decode_en;
    logic is_load;
    logic is_store;

    assign is_load = (instruction.i_fmt.opcode == OP_LOAD);
    assign is_store = (instruction.s_fmt.opcode == OP_STORE);
    assign decode_en = (state == WAIT_INSTR) && system_bus_read_data_valid;
    assign retire = (state == WRITEBACK);

    // ========================================================================
    // State sequencing
    // ========================================================================

    always_comb begin
        state_next = state;
        case (state)
            FETCH: if (system_bus_ready) state_next = WAIT_INSTR;
            WAIT_INSTR: if (system_bus_read_data_valid) state_next = EXECUTE;
            EXECUTE: state_next = (is_load || is_store) ? MEM_REQ : WRITEBACK;
            MEM_REQ: begin
                if (system_bus_ready) begin
                    state_next = is_load ? WAIT_LOAD : WRITEBACK;
                end
            end
            WAIT_LOAD: if (system_bus_read_data_valid) state_next = WRITEBACK;
            WRITEBACK: state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc <= RESET_PC;
            instruction <= NOP_WORD;
        end else begin
            state <= state_next;
            if (decode_en) begin
                instruction <= system_bus_read_data;
            end
            if (pc_write_enable) begin
                pc <= pc_write_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_LOAD && system_bus_read_data_valid) begin
            load_data <= system_bus_read_data;
        end
    end

    // ========================================================================
    // System bus
    // ========================================================================

    // Requests are decoded from the state so they hold until ready
    always_comb begin
        system_bus_read_req = 1'b0;
        system_bus_write_req = 1'b0;
        system_bus_addr = '0;
        system_bus_write_data = '0;
        system_bus_byte_enable = '0;
        if (state == FETCH && !reset) begin
            system_bus_read_req = 1'b1;
            system_bus_addr = pc;
            system_bus_byte_enable = 4'b1111;
        end else if (state == MEM_REQ && !reset) begin
            system_bus_read_req = is_load;
            system_bus_write_req = is_store;
            system_bus_addr = mem_addr;
            system_bus_write_data = is_store ? store_data : '0;
            system_bus_byte_enable = is_store ? store_byte_en : 4'b1111;
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (system_bus_read_req || system_bus_write_req) && !system_bus_ready
        |=> (system_bus_read_req || system_bus_write_req)
            && $stable(system_bus_addr) && $stable(system_bus_write_data)
    );

    a_req_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(system_bus_read_req && system_bus_write_req)
    );

endmodule

`default_nettype wire

/* src/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input wire clk,
    input wire reset,

    input wire system_bus_ready,
    output cpu_pkg::word_t system_bus_addr,
    output cpu_pkg::word_t system_bus_write_data,
    output cpu_pkg::byte_en_t system_bus_byte_enable,
    output logic system_bus_write_req,
    output logic system_bus_read_req,
    input wire cpu_pkg::word_t system_bus_read_data,
    input wire system_bus_read_data_valid
);
    import cpu_pkg::*;

    operand_if ops ();

    word_t alu_result;
    word_t mem_addr;
    word_t store_data;
    byte_en_t store_byte_en;
    word_t next_pc;
    word_t link;
    word_t load_data;
    logic retire;

    logic reg_write_enable;
    reg_addr_t reg_write_addr;
    word_t reg_write_data;
    logic pc_write_enable;
    word_t pc_write_data;

    control control0 (
        .clk(clk),
        .reset(reset),
        .system_bus_ready(system_bus_ready),
        .system_bus_addr(system_bus_addr),
        .system_bus_write_data(system_bus_write_data),
        .system_bus_byte_enable(system_bus_byte_enable),
        .system_bus_write_req(system_bus_write_req),
        .system_bus_read_req(system_bus_read_req),
        .system_bus_read_data(system_bus_read_data),
        .system_bus_read_data_valid(system_bus_read_data_valid),
        .mem_addr(mem_addr),
        .store_data(store_data),
        .store_byte_en(store_byte_en),
        .pc_write_enable(pc_write_enable),
        .pc_write_data(pc_write_data),
        .instruction(ops.instruction),
        .pc(ops.pc),
        .load_data(load_data),
        .retire(retire)
    );

    register_file register_file0 (
        .clk(clk),
        .reset(reset),
        .read_addr1(ops.instruction.r_fmt.rs1),
        .read_data1(ops.rs1_data),
        .read_addr2(ops.instruction.r_fmt.rs2),
        .read_data2(ops.rs2_data),
        .write_enable(reg_write_enable),
        .write_addr(reg_write_addr),
        .write_data(reg_write_data)
    );

    alu alu0 (
        .ops(ops.sink),
        .result(alu_result),
        .mem_addr(mem_addr),
        .store_data(store_data),
        .store_byte_en(store_byte_en)
    );

    branch_unit branch_unit0 (
        .ops(ops.sink),
        .next_pc(next_pc),
        .link(link)
    );

    writeback writeback0 (
        .retire(retire),
        .instruction(ops.instruction),
        .alu_result(alu_result),
        .load_data(load_data),
        .link(link),
        .next_pc(next_pc),
        .reg_write_enable(reg_write_enable),
        .reg_write_addr(reg_write_addr),
        .reg_write_data(reg_write_data),
        .pc_write_enable(pc_write_enable),
        .pc_write_data(pc_write_data)
    );

endmodule

`default_nettype wire

/* bench/bus_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_memory #(
    parameter logic [31:0] SEED = 32'd1
) (
    input wire clk,
    input wire reset,

    output logic ready,
    input wire cpu_pkg::word_t addr,
    input wire cpu_pkg::word_t write_data,
    input wire cpu_pkg::byte_en_t byte_enable,
    input wire write_req,
    input wire read_req,
    output cpu_pkg::word_t read_data,
    output logic read_data_valid
);
    import cpu_pkg::*;

    // 1 KB, word indexed by addr[9:2]
    word_t mem [0:255];

    initial begin : responder
        int stall;
        int latency;
        logic busy;
        logic reading;
        logic in_reset;
        word_t pending_data;
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        ready = 1'b0;
        read_data = '0;
        read_data_valid = 1'b0;
        busy = 1'b0;
        reading = 1'b0;
        stall = 0;
        latency = 0;
        pending_data = '0;
        forever begin
            @(posedge clk);
            in_reset = reset;
            #1;
            ready = 1'b0;
            read_data_valid = 1'b0;
            if (in_reset) begin
                busy = 1'b0;
                reading = 1'b0;
            end else if (reading) begin
                latency--;
                if (latency == 0) begin
                    read_data = pending_data;
                    read_data_valid = 1'b1;
                    reading = 1'b0;
                end
            end else if (read_req || write_req) begin
                // A new request draws its own stall length
                if (!busy) begin
                    busy = 1'b1;
                    stall = $urandom_range(3, 0);
                end
                if (stall > 0) begin
                    stall--;
                end else begin
                    ready = 1'b1;
                    busy = 1'b0;
                    if (write_req) begin
                        for (int b = 0; b < 4; b++) begin
                            if (byte_enable[b]) begin
                                mem[addr[9:2]][8*b +: 8] = write_data[8*b +: 8];
                            end
                        end
                    end else begin
                        pending_data = mem[addr[9:2]];
                        latency = $urandom_range(4, 1);
                        reading = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        EV_NONE,
        EV_STORE,
        EV_FETCH
    } event_kind_e;

    typedef struct packed {
        word_t instr;
        event_kind_e kind;
        word_t addr;
        word_t data;
        byte_en_t be;
    } row_t;

    logic clk;
    logic reset;
    logic system_bus_ready;
    word_t system_bus_addr;
    word_t system_bus_write_data;
    byte_en_t system_bus_byte_enable;
    logic system_bus_write_req;
    logic system_bus_read_req;
    word_t system_bus_read_data;
    logic system_bus_read_data_valid;

    row_t rows[$];
    int event_rows[$];

    cpu u_cpu (
        .clk(clk),
        .reset(reset),
        .system_bus_ready(system_bus_ready),
        .system_bus_addr(system_bus_addr),
        .system_bus_write_data(system_bus_write_data),
        .system_bus_byte_enable(system_bus_byte_enable),
        .system_bus_write_req(system_bus_write_req),
        .system_bus_read_req(system_bus_read_req),
        .system_bus_read_data(system_bus_read_data),
        .system_bus_read_data_valid(system_bus_read_data_valid)
    );

    bus_memory #(.SEED(32'hd7be_a343)) u_memory (
        .clk(clk),
        .reset(reset),
        .ready(system_bus_ready),
        .addr(system_bus_addr),
        .write_data(system_bus_write_data),
        .byte_enable(system_bus_byte_enable),
        .write_req(system_bus_write_req),
        .read_req(system_bus_read_req),
        .read_data(system_bus_read_data),
        .read_data_valid(system_bus_read_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // RV32I encoders
    // ========================================================================

    function automatic word_t reg_instr(input logic [6:0] f7, input logic [2:0] f3,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t imm_instr(input logic [6:0] opcode, input logic [2:0] f3,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic word_t store_instr(input logic [2:0] f3, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branch_instr(input logic [2:0] f3, input reg_addr_t rs1,
                                           input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t lui_instr(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic word_t jal_instr(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t lane_mask(input byte_en_t be);
        word_t mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return mask;
    endfunction

    task automatic plain_row(input word_t instr);
        rows.push_back({instr, EV_NONE, 32'd0, 32'd0, 4'd0});
    endtask

    task automatic store_row(input word_t instr, input word_t addr, input word_t data,
                             input byte_en_t be);
        rows.push_back({instr, EV_STORE, addr, data, be});
    endtask

    // Target is the address of the fetch that follows this instruction
    task automatic fetch_row(input word_t instr, input word_t target);
        rows.push_back({instr, EV_FETCH, target, 32'd0, 4'd0});
    endtask

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_store(input word_t exp_addr, input word_t exp_data,
                               input byte_en_t exp_be);
        word_t mask;
        mask = lane_mask(exp_be);
        if (system_bus_addr !== exp_addr || system_bus_byte_enable !== exp_be
                || (system_bus_write_data & mask) !== (exp_data & mask)) begin
            $display("[ERROR] %0t: store expected addr %h data %h be %b, got %h %h %b",
                     $time, exp_addr, exp_data, exp_be, system_bus_addr,
                     system_bus_write_data, system_bus_byte_enable);
            abort_run();
        end
    endtask

    task automatic check_fetch(input word_t exp_addr);
        if (system_bus_addr !== exp_addr) begin
            $display("[ERROR] %0t: fetch expected addr %h, got %h",
                     $time, exp_addr, system_bus_addr);
            abort_run();
        end
    endtask

    initial begin : watchdog
        @(negedge reset);
        repeat (rows.size() * 40) @(posedge clk);
        $display("The program did not finish within %0d cycles", rows.size() * 40);
        abort_run();
    end

    // ========================================================================
    // Program and event walk
    // ========================================================================

    initial begin : main
        int next_event;
        int row;
        logic load_next;
        logic target_pending;
        row_t exp;
        reset = 1'b1;

        plain_row(imm_instr(OP_IMM, F3_ADD, 10, 0, 12'h200));
        plain_row(imm_instr(OP_IMM, F3_ADD, 1, 0, 12'd100));
        plain_row(imm_instr(OP_IMM, F3_ADD, 2, 0, 12'hFF9));
        plain_row(lui_instr(3, 20'h12345));
        plain_row(imm_instr(OP_IMM, F3_ADD, 3, 3, 12'h678));
        plain_row(reg_instr(7'd0, F3_ADD, 4, 1, 2));
        store_row(store_instr(F3_SW, 4, 10, 12'd0), 32'h200, 32'h0000_005D, 4'b1111);
        plain_row(reg_instr(F7_SUB, F3_ADD, 5, 1, 2));
        store_row(store_instr(F3_SW, 5, 10, 12'd4), 32'h204, 32'h0000_006B, 4'b1111);
        plain_row(reg_instr(7'd0, F3_AND, 6, 3, 1));
        store_row(store_instr(F3_SW, 6, 10, 12'd8), 32'h208, 32'h0000_0060, 4'b1111);
        plain_row(reg_instr(7'd0, F3_OR, 7, 3, 1));
        store_row(store_instr(F3_SW, 7, 10, 12'd12), 32'h20C, 32'h1234_567C, 4'b1111);
        plain_row(reg_instr(7'd0, F3_XOR, 8, 3, 2));
        store_row(store_instr(F3_SW, 8, 10, 12'd16), 32'h210, 32'hEDCB_A981, 4'b1111);
        plain_row(reg_instr(7'd0, F3_SLT, 9, 2, 1));
        store_row(store_instr(F3_SW, 9, 10, 12'd20), 32'h214, 32'h0000_0001, 4'b1111);
        plain_row(reg_instr(7'd0, F3_SLTU, 11, 2, 1));
        store_row(store_instr(F3_SW, 11, 10, 12'd24), 32'h218, 32'h0000_0000, 4'b1111);
        plain_row(imm_instr(OP_IMM, F3_XOR, 12, 1, 12'hFFF));
        store_row(store_instr(F3_SW, 12, 10, 12'd28), 32'h21C, 32'hFFFF_FF9B, 4'b1111);
        plain_row(imm_instr(OP_IMM, F3_AND, 13, 2, 12'h7F0));
        store_row(store_instr(F3_SW, 13, 10, 12'd32), 32'h220, 32'h0000_07F0, 4'b1111);
        plain_row(imm_instr(OP_IMM, F3_OR, 14, 1, 12'hF00));
        store_row(store_instr(F3_SW, 14, 10, 12'd36), 32'h224, 32'hFFFF_FF64, 4'b1111);
        plain_row(imm_instr(OP_IMM, F3_SLT, 15, 2, 12'hFFA));
        store_row(store_instr(F3_SW, 15, 10, 12'd40), 32'h228, 32'h0000_0001, 4'b1111);
        plain_row(lui_instr(16, 20'hFEDCB));
        plain_row(imm_instr(OP_IMM, F3_ADD, 16, 16, 12'h800));
        store_row(store_instr(F3_SW, 16, 10, 12'd44), 32'h22C, 32'hFEDC_A800, 4'b1111);
        // Two byte stores into one word, then read it back as a whole
        store_row(store_instr(F3_SB, 3, 10, 12'd49), 32'h231, 32'h0000_7800, 4'b0010);
        store_row(store_instr(F3_SB, 1, 10, 12'd51), 32'h233, 32'h6400_0000, 4'b1000);
        plain_row(imm_instr(OP_LOAD, 3'b010, 17, 10, 12'd48));
        store_row(store_instr(F3_SW, 17, 10, 12'd52), 32'h234, 32'h6400_7800, 4'b1111);
        // Rows skipped by a taken branch hold stores that must never appear
        fetch_row(branch_instr(F3_BEQ, 1, 1, 13'd8), 32'd144);
        plain_row(store_instr(F3_SW, 1, 10, 12'd56));
        fetch_row(branch_instr(F3_BEQ, 1, 2, 13'd8), 32'd148);
        fetch_row(branch_instr(F3_BNE, 1, 2, 13'd8), 32'd156);
        plain_row(store_instr(F3_SW, 1, 10, 12'd56));
        fetch_row(branch_instr(F3_BNE, 1, 1, 13'd8), 32'd160);
        fetch_row(branch_instr(F3_BLT, 2, 1, 13'd8), 32'd168);
        plain_row(store_instr(F3_SW, 1, 10, 12'd56));
        fetch_row(branch_instr(F3_BLT, 1, 2, 13'd8), 32'd172);
        fetch_row(branch_instr(F3_BGE, 1, 2, 13'd8), 32'd180);
        plain_row(store_instr(F3_SW, 1, 10, 12'd56));
        fetch_row(branch_instr(F3_BGE, 2, 1, 13'd8), 32'd184);
        fetch_row(jal_instr(18, 21'd12), 32'd196);
        plain_row(store_instr(F3_SW, 1, 10, 12'd56));
        plain_row(store_instr(F3_SW, 1, 10, 12'd56));
        store_row(store_instr(F3_SW, 18, 10, 12'd56), 32'h238, 32'h0000_00BC, 4'b1111);
        plain_row(imm_instr(OP_IMM, F3_ADD, 0, 1, 12'd5));
        store_row(store_instr(F3_SW, 0, 10, 12'd60), 32'h23C, 32'h0000_0000, 4'b1111);
        // Jump to itself, the run ends on this fetch
        fetch_row(jal_instr(0, 21'd0), 32'd208);

        @(posedge clk);
        #1;
        for (int i = 0; i < rows.size(); i++) begin
            u_memory.mem[i] = rows[i].instr;
            if (rows[i].kind != EV_NONE) begin
                event_rows.push_back(i);
            end
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        next_event = 0;
        load_next = 1'b0;
        target_pending = 1'b0;
        while (next_event < event_rows.size()) begin
            @(negedge clk);
            exp = rows[event_rows[next_event]];
            if (system_bus_write_req && system_bus_ready) begin
                if (exp.kind != EV_STORE) begin
                    $display("A store to %h happened where none was expected", system_bus_addr);
                    abort_run();
                end
                check_store(exp.addr, exp.data, exp.be);
                next_event++;
            end else if (system_bus_read_req && system_bus_ready && load_next) begin
                load_next = 1'b0;
            end else if (system_bus_read_req && system_bus_ready) begin
                if (target_pending) begin
                    if (exp.kind != EV_FETCH) begin
                        $display("An expected store to %h never happened", exp.addr);
                        abort_run();
                    end
                    check_fetch(exp.addr);
                    next_event++;
                    target_pending = 1'b0;
                end
                row = system_bus_addr >> 2;
                if (row >= rows.size()) begin
                    $display("The core fetched from %h, outside the program", system_bus_addr);
                    abort_run();
                end
                load_next = (rows[row].instr[6:0] == 7'b0000011);
                target_pending = (rows[row].kind == EV_FETCH);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
src/cpu_pkg.sv
src/operand_if.sv
src/register_file.sv
src/alu.sv
src/branch_unit.sv
src/writeback.sv
src/control.sv
src/cpu.sv
bench/bus_memory.sv
bench/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f flist.f -o cpu_sim

# The simulator exits non-zero on a fatal check, the grep below decides the result
output=$(./obj_dir/cpu_sim || true)
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
